// ==== msx_shell_macros.svh ====
/*
 * Width, crop table and timing constants for the MSX wrapper glue.
 * Covers video framing, SD activity timing and the cassette download index.
 */
`ifndef MSX_SHELL_MACROS_SVH
`define MSX_SHELL_MACROS_SVH

// Word widths
`define HDMI_DIM_W      12
`define CROP_W          10
`define AR_W            12
`define DDR3_AW         28

// Crop table results and the 4:3 width threshold
`define CROP_200        10'd200
`define CROP_216        10'd216
`define CROP_240        10'd240
`define CROP_256        10'd256
`define W43_MIN_WIDTH   12'd1440

// Default aspect words
`define AR_ORIG_X       12'd400
`define AR_WIDE_X       12'd340
`define AR_ORIG_Y       12'd300

// Roughly 47 ms of LED afterglow at 21.48 MHz
`define SD_ACT_TIMEOUT  1000000
`define CAS_INDEX       6'd5

`endif

// ==== msx_shell_pkg.sv ====
/*
 * Shared packed struct types for the MSX wrapper glue:
 * video settings and framing result, SPI bundle, DDR3 read requester
 * and tape settings.
 */
`include "msx_shell_macros.svh"

package msx_shell_pkg;

   // User video menu settings
   typedef struct packed {
      logic [1:0] ar;
      logic [1:0] scanlines;
      logic [1:0] scale;
      logic       vcrop_en;
   } video_cfg_t;

   // Framing words handed to the scaler
   typedef struct packed {
      logic [`AR_W-1:0]   arx;
      logic [`AR_W-1:0]   ary;
      logic [`CROP_W-1:0] crop;
      logic [1:0]         scale;
   } video_geom_t;

   typedef struct packed {
      logic sck;
      logic mosi;
      logic cs;
   } spi_lines_t;

   // One requester on the shared DDR3 read port
   typedef struct packed {
      logic [`DDR3_AW-1:0] addr;
      logic                rd;
      logic                req;
   } ddr3_rd_t;

   // src_adc low selects the tape file, high the ADC input
   typedef struct packed {
      logic src_adc;
      logic rewind;
      logic detach;
   } tape_cfg_t;

endpackage

// ==== video_crop.sv ====
/*
 * Vertical crop and wide flag chosen from the HDMI output size,
 * plus the aspect-ratio words, crop size and scale for the scaler.
 */
`timescale 1ns/10ps
`include "msx_shell_macros.svh"

module video_crop
   import msx_shell_pkg::*;
(
   input  logic                   clk21m,
   input  logic                   rst,
   input  logic [`HDMI_DIM_W-1:0] hdmi_width,
   input  logic [`HDMI_DIM_W-1:0] hdmi_height,
   input  logic                   scandoubler,
   input  video_cfg_t             cfg,
   output video_geom_t            geom
);

   logic [`HDMI_DIM_W:0] h_span;
   logic                 wide_fit;
   logic                 tall_fit;
   logic [`CROP_W-1:0]   crop_nxt;
   logic                 wide_nxt;
   logic [`CROP_W-1:0]   crop_q;
   logic                 wide_q;

   // Height plus half height in one extra bit
   assign h_span   = {1'b0, hdmi_height} + {2'b00, hdmi_height[`HDMI_DIM_W-1:1]};
   assign wide_fit = {1'b0, hdmi_width} >= h_span;
   assign tall_fit = hdmi_width >= `W43_MIN_WIDTH;

   // ========================================
   // Crop table
   // ========================================
   always_comb begin
      crop_nxt = '0;
      wide_nxt = 1'b0;
      if (!scandoubler) begin
         if (wide_fit) begin
            case (hdmi_height)
               12'd480, 12'd720: crop_nxt = `CROP_240;
               12'd600, 12'd800: begin
                  crop_nxt = `CROP_200;
                  wide_nxt = cfg.vcrop_en;
               end
               12'd768:  crop_nxt = `CROP_256;
               12'd1080: crop_nxt = `CROP_216;
               12'd1200: crop_nxt = `CROP_240;
               default:  crop_nxt = '0;
            endcase
         end else if (tall_fit) begin
            // 4:3 modes like 1920x1440 miss the 1.5 ratio test
            case (hdmi_height)
               12'd1440: crop_nxt = `CROP_240;
               12'd1536: crop_nxt = `CROP_256;
               default:  crop_nxt = '0;
            endcase
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (rst) begin
         crop_q <= '0;
         wide_q <= 1'b0;
      end else begin
         crop_q <= crop_nxt;
         wide_q <= wide_nxt;
      end
   end

   // ========================================
   // Scaler words
   // ========================================
   always_comb begin
      if (cfg.ar == 2'd0) begin
         geom.arx = wide_q ? `AR_WIDE_X : `AR_ORIG_X;
         geom.ary = `AR_ORIG_Y;
      end else begin
         // Custom aspect slots are passed as index values
         geom.arx = {{(`AR_W-2){1'b0}}, cfg.ar - 2'd1};
         geom.ary = '0;
      end
      geom.crop  = cfg.vcrop_en ? crop_q : '0;
      geom.scale = cfg.scale;
   end

endmodule

// ==== sd_route.sv ====
/*
 * Virtual SD image versus physical card selection, SPI line steering,
 * bus activity timer and the disk and user LED drives.
 */
`timescale 1ns/10ps
`include "msx_shell_macros.svh"

module sd_route
   import msx_shell_pkg::*;
#(
   parameter int ACT_TIMEOUT = `SD_ACT_TIMEOUT
) (
   input  logic       clk21m,
   input  logic       rst,
   input  logic       vsd_mounted,
   input  logic       vsd_size_nz,
   input  spi_lines_t master,
   output logic       master_miso,
   input  logic       vsd_miso,
   input  logic       sd_miso,
   output spi_lines_t sd_pins,
   output logic       vsd_sel,
   output logic       led_user,
   output logic [1:0] led_disk
);

   localparam int CNT_W = $clog2(ACT_TIMEOUT + 1);
   localparam logic [CNT_W-1:0] ACT_MAX = CNT_W'(ACT_TIMEOUT);

   logic             mosi_q;
   logic             miso_q;
   logic [CNT_W-1:0] act_cnt;
   logic             sd_act;

   // A mounted image with data takes over from the physical card
   always_ff @(posedge clk21m) begin
      if (rst) begin
         vsd_sel <= 1'b0;
      end else if (vsd_mounted) begin
         vsd_sel <= vsd_size_nz;
      end
   end

   // Physical card is parked while the image is live
   always_comb begin
      sd_pins.cs   = vsd_sel;
      sd_pins.sck  = master.sck & ~vsd_sel;
      sd_pins.mosi = master.mosi & ~vsd_sel;
      master_miso  = vsd_sel ? vsd_miso : sd_miso;
   end

   // ========================================
   // Activity timer
   // ========================================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         mosi_q  <= 1'b0;
         miso_q  <= 1'b0;
         act_cnt <= ACT_MAX;
         sd_act  <= 1'b0;
      end else begin
         mosi_q <= master.mosi;
         miso_q <= master_miso;
         sd_act <= act_cnt < ACT_MAX;
         if ((mosi_q ^ master.mosi) || (miso_q ^ master_miso)) begin
            act_cnt <= '0;
         end else if (act_cnt < ACT_MAX) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

// ==== media_route.sv ====
/*
 * Cassette input source select, player start and rewind conditions,
 * and the loader-first share of the DDR3 read port.
 */
`timescale 1ns/10ps
`include "msx_shell_macros.svh"

module media_route
   import msx_shell_pkg::*;
(
   input  logic        core_rst,
   input  tape_cfg_t   tape,
   input  logic        cas_file_bit,
   input  logic        adc_bit,
   input  logic        adc_active,
   input  logic        cas_motor,
   input  logic        dl_active,
   input  logic [15:0] dl_index,
   input  ddr3_rd_t    loader_rd,
   input  ddr3_rd_t    cas_rd,
   output ddr3_rd_t    ddr3_rd,
   output logic        cas_audio,
   output logic        cas_play,
   output logic        cas_rewind
);

   logic cas_download;

   // ========================================
   // Tape
   // ========================================
   // ADC level only counts while the converter reports a signal
   assign cas_audio    = tape.src_adc ? (adc_bit & adc_active) : cas_file_bit;

   // Motor relay is active low on the MSX side
   assign cas_play     = ~cas_motor;

   // A fresh CAS download restarts the tape from its start
   assign cas_download = dl_active & (dl_index[5:0] == `CAS_INDEX);
   assign cas_rewind   = tape.rewind | cas_download | core_rst;

   // ========================================
   // DDR3 read port
   // ========================================
   // Loader wins for as long as it holds its request, data and ready
   // go to both sides untouched
   assign ddr3_rd = loader_rd.req ? loader_rd : cas_rd;

endmodule

// ==== msx_shell_top.sv ====
/*
 * Top level of the MSX wrapper glue: core reset combine,
 * video framing, SD routing and media routing blocks.
 */
`timescale 1ns/10ps
`include "msx_shell_macros.svh"

module msx_shell_top
   import msx_shell_pkg::*;
#(
   parameter int ACT_TIMEOUT = `SD_ACT_TIMEOUT
) (
   input  logic                   clk21m,
   input  logic                   rst,
   input  logic                   reset_menu,
   input  logic                   loader_reset_rq,
   // Video
   input  logic [`HDMI_DIM_W-1:0] hdmi_width,
   input  logic [`HDMI_DIM_W-1:0] hdmi_height,
   input  logic                   scandoubler,
   input  video_cfg_t             cfg,
   output video_geom_t            geom,
   // SD card
   input  logic                   vsd_mounted,
   input  logic                   vsd_size_nz,
   input  spi_lines_t             master,
   output logic                   master_miso,
   input  logic                   vsd_miso,
   input  logic                   sd_miso,
   output spi_lines_t             sd_pins,
   output logic                   vsd_sel,
   output logic                   led_user,
   output logic [1:0]             led_disk,
   // Tape and DDR3
   input  tape_cfg_t              tape,
   input  logic                   cas_file_bit,
   input  logic                   adc_bit,
   input  logic                   adc_active,
   input  logic                   cas_motor,
   input  logic                   dl_active,
   input  logic [15:0]            dl_index,
   input  ddr3_rd_t               loader_rd,
   input  ddr3_rd_t               cas_rd,
   output ddr3_rd_t               ddr3_rd,
   output logic                   cas_audio,
   output logic                   cas_play,
   output logic                   cas_rewind
);

   logic core_rst;

   // Menu reset, reset-and-detach and loader request all restart the core
   assign core_rst = rst | reset_menu | tape.detach | loader_reset_rq;

   // ========================================
   // Blocks
   // ========================================
   video_crop u_video_crop (
      .clk21m      (clk21m),
      .rst         (rst),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .scandoubler (scandoubler),
      .cfg         (cfg),
      .geom        (geom)
   );

   sd_route #(
      .ACT_TIMEOUT (ACT_TIMEOUT)
   ) u_sd_route (
      .clk21m      (clk21m),
      .rst         (core_rst),
      .vsd_mounted (vsd_mounted),
      .vsd_size_nz (vsd_size_nz),
      .master      (master),
      .master_miso (master_miso),
      .vsd_miso    (vsd_miso),
      .sd_miso     (sd_miso),
      .sd_pins     (sd_pins),
      .vsd_sel     (vsd_sel),
      .led_user    (led_user),
      .led_disk    (led_disk)
   );

   media_route u_media_route (
      .core_rst     (core_rst),
      .tape         (tape),
      .cas_file_bit (cas_file_bit),
      .adc_bit      (adc_bit),
      .adc_active   (adc_active),
      .cas_motor    (cas_motor),
      .dl_active    (dl_active),
      .dl_index     (dl_index),
      .loader_rd    (loader_rd),
      .cas_rd       (cas_rd),
      .ddr3_rd      (ddr3_rd),
      .cas_audio    (cas_audio),
      .cas_play     (cas_play),
      .cas_rewind   (cas_rewind)
   );

endmodule

// ==== msx_shell_assert.sv ====
/*
 * Concurrent checks bound to the wrapper top: parked physical SPI lines,
 * constant disk LED bit and loader priority on the DDR3 read port.
 */
`timescale 1ns/10ps

module msx_shell_assert
   import msx_shell_pkg::*;
(
   input logic       clk21m,
   input logic       rst,
   input logic       vsd_sel,
   input spi_lines_t sd_pins,
   input logic [1:0] led_disk,
   input ddr3_rd_t   loader_rd,
   input ddr3_rd_t   ddr3_rd
);

   int fail_cnt = 0;

   // Physical card idle while the image is live
   a_parked: assert property (@(posedge clk21m) disable iff (rst)
      vsd_sel |-> (!sd_pins.sck && !sd_pins.mosi))
      else begin
         $error("Physical sck or mosi driven while the virtual card is selected");
         fail_cnt++;
      end

   a_led_bit1: assert property (@(posedge clk21m) disable iff (rst) led_disk[1])
      else begin
         $error("Disk LED bit 1 dropped low");
         fail_cnt++;
      end

   a_loader_first: assert property (@(posedge clk21m) disable iff (rst)
      loader_rd.req |-> (ddr3_rd.addr == loader_rd.addr))
      else begin
         $error("DDR3 address differs from the loader address while it owns the port");
         fail_cnt++;
      end

endmodule

bind msx_shell_top msx_shell_assert u_assert (
   .clk21m    (clk21m),
   .rst       (rst),
   .vsd_sel   (vsd_sel),
   .sd_pins   (sd_pins),
   .led_disk  (led_disk),
   .loader_rd (loader_rd),
   .ddr3_rd   (ddr3_rd)
);

// ==== tb_msx_shell.sv ====
/*
 * Testbench for the MSX wrapper glue: clock, reset, LFSR stimulus,
 * directed tests for crop, SD routing, activity LEDs, tape and DDR3.
 */
`timescale 1ns/10ps
`include "msx_shell_macros.svh"

module tb_msx_shell
   import msx_shell_pkg::*;
();

   // Tests need about 160 cycles
   localparam int MAX_CYCLES = 2000;

   logic clk21m, rst, reset_menu, loader_reset_rq;
   logic [`HDMI_DIM_W-1:0] hdmi_width, hdmi_height;
   logic scandoubler;
   video_cfg_t cfg;
   video_geom_t geom;
   logic vsd_mounted, vsd_size_nz, master_miso, vsd_miso, sd_miso;
   spi_lines_t master, sd_pins;
   logic vsd_sel, led_user;
   logic [1:0] led_disk;
   tape_cfg_t tape;
   logic cas_file_bit, adc_bit, adc_active, cas_motor, dl_active;
   logic [15:0] dl_index;
   ddr3_rd_t loader_rd, cas_rd, ddr3_rd;
   logic cas_audio, cas_play, cas_rewind;
   int errors = 0;
   int checks = 0;
   int cycles = 0;
   logic [15:0] lfsr = 16'd3;

   msx_shell_top #(.ACT_TIMEOUT(20)) u_dut (.*);

   always #4 clk21m = ~clk21m;

   always @(posedge clk21m) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Run stopped after %0d cycles before the tests finished", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   // ========================================
   // Helpers
   // ========================================
   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // Leaves time 1 ns past the edge, where inputs get driven
   task automatic tick(input int n);
      repeat (n) begin
         @(posedge clk21m);
         #1;
      end
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s: got %h expected %h", name, got, exp);
      end
   endtask

   function automatic logic led_of(input logic virt);
      return virt ? led_user : led_disk[0];
   endfunction

   task automatic mount(input logic size_nz);
      vsd_size_nz = size_nz;
      vsd_mounted = 1'b1;
      tick(1);
      vsd_mounted = 1'b0;
      tick(1);
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while ((led_user || led_disk[0]) && n < 40) begin
         tick(1);
         n++;
      end
      if (led_user || led_disk[0]) begin
         errors++;
         $display("Activity LEDs stayed lit on an idle bus");
      end
   endtask

   // ========================================
   // Tests
   // ========================================
   task automatic test_reset();
      check("vsd_sel", vsd_sel, 0);
      check("led_user", led_user, 0);
      check("led_disk[0]", led_disk[0], 0);
      check("geom.crop", geom.crop, 0);
   endtask

   task automatic crop_case(input int w, input int h, input logic sd, input int exp_crop,
                            input int exp_arx);
      hdmi_width = w;
      hdmi_height = h;
      scandoubler = sd;
      tick(2);
      check("geom.crop", geom.crop, exp_crop);
      check("geom.arx", geom.arx, exp_arx);
   endtask

   task automatic test_crop();
      logic [31:0] h;
      cfg = '{ar: 2'd0, scanlines: 2'd0, scale: 2'd0, vcrop_en: 1'b1};
      crop_case(800, 480, 1'b0, 240, 400);
      crop_case(1280, 720, 1'b0, 240, 400);
      crop_case(1024, 600, 1'b0, 200, 340);
      crop_case(1280, 800, 1'b0, 200, 340);
      crop_case(1366, 768, 1'b0, 256, 400);
      crop_case(1920, 1080, 1'b0, 216, 400);
      crop_case(1920, 1200, 1'b0, 240, 400);
      crop_case(1920, 1440, 1'b0, 240, 400);
      crop_case(2048, 1536, 1'b0, 256, 400);
      crop_case(1920, 1080, 1'b1, 0, 400);
      for (int i = 0; i < 8; i++) begin
         take_bits(12, h);
         if (h inside {480, 600, 720, 768, 800, 1080, 1200, 1440, 1536})
            h = h + 1;
         crop_case(1920, h, 1'b0, 0, 400);
      end
      cfg.ar = 2'd2;
      crop_case(1920, 1080, 1'b0, 216, 1);
      check("geom.ary", geom.ary, 0);
      // Scanlines leave the crop alone, scale passes straight through
      cfg.ar = 2'd0;
      cfg.scanlines = 2'd1;
      cfg.scale = 2'd3;
      crop_case(1920, 1080, 1'b0, 216, 400);
      check("geom.ary", geom.ary, 300);
      check("geom.scale", geom.scale, 3);
      cfg.vcrop_en = 1'b0;
      crop_case(1280, 800, 1'b0, 0, 400);
      cfg = '{ar: 2'd0, scanlines: 2'd0, scale: 2'd0, vcrop_en: 1'b1};
   endtask

   task automatic test_vsd();
      master = '{sck: 1'b1, mosi: 1'b1, cs: 1'b0};
      vsd_miso = 1'b1;
      sd_miso = 1'b0;
      mount(1'b1);
      check("vsd_sel", vsd_sel, 1);
      check("sd_pins", sd_pins, 3'b001);
      check("master_miso", master_miso, 1);
      mount(1'b0);
      check("vsd_sel", vsd_sel, 0);
      check("sd_pins", sd_pins, 3'b110);
      check("master_miso", master_miso, 0);
      master = '0;
      vsd_miso = 1'b0;
   endtask

   task automatic test_glow(input logic virt);
      int lit_at;
      int dark_at;
      mount(virt);
      wait_idle();
      master.mosi = ~master.mosi;
      lit_at = 0;
      dark_at = 0;
      for (int n = 1; n <= 40 && dark_at == 0; n++) begin
         tick(1);
         if (lit_at == 0 && led_of(virt))
            lit_at = n;
         else if (lit_at != 0 && !led_of(virt))
            dark_at = n;
      end
      checks += 2;
      if (lit_at == 0 || lit_at > 2) begin
         errors++;
         $display("LED did not light within 2 cycles of a mosi toggle");
      end
      if (dark_at < 20 || dark_at > 23) begin
         errors++;
         $display("LED went dark %0d cycles after the toggle, not within 20 to 23", dark_at);
      end
   endtask

   task automatic test_tape();
      logic [31:0] a;
      cas_file_bit = 1'b1;
      tick(1);
      check("cas_audio", cas_audio, 1);
      check("cas_play", cas_play, 1);
      cas_file_bit = 1'b0;
      tape.src_adc = 1'b1;
      adc_bit = 1'b1;
      tick(1);
      check("cas_audio", cas_audio, 0);
      adc_active = 1'b1;
      cas_motor = 1'b1;
      tick(1);
      check("cas_audio", cas_audio, 1);
      check("cas_play", cas_play, 0);
      check("cas_rewind", cas_rewind, 0);
      tape.rewind = 1'b1;
      tick(1);
      check("cas_rewind", cas_rewind, 1);
      tape.rewind = 1'b0;
      dl_active = 1'b1;
      dl_index = 16'd5;
      tick(1);
      check("cas_rewind", cas_rewind, 1);
      dl_index = 16'd3;
      tick(1);
      check("cas_rewind", cas_rewind, 0);
      dl_active = 1'b0;
      reset_menu = 1'b1;
      tick(1);
      check("cas_rewind", cas_rewind, 1);
      reset_menu = 1'b0;
      // Loader owns the port first, then hands it back
      take_bits(28, a);
      loader_rd = '{addr: a[27:0], rd: 1'b1, req: 1'b1};
      take_bits(28, a);
      cas_rd = '{addr: a[27:0], rd: 1'b0, req: 1'b0};
      tick(1);
      check("ddr3_rd.addr", ddr3_rd.addr, loader_rd.addr);
      check("ddr3_rd.rd", ddr3_rd.rd, 1);
      loader_rd.req = 1'b0;
      tick(1);
      check("ddr3_rd.addr", ddr3_rd.addr, cas_rd.addr);
      check("ddr3_rd.rd", ddr3_rd.rd, 0);
   endtask

   initial begin
      clk21m = 1'b0;
      rst = 1'b1;
      reset_menu = 1'b0;
      loader_reset_rq = 1'b0;
      hdmi_width = '0;
      hdmi_height = '0;
      scandoubler = 1'b0;
      cfg = '{ar: 2'd0, scanlines: 2'd0, scale: 2'd0, vcrop_en: 1'b1};
      vsd_mounted = 1'b0;
      vsd_size_nz = 1'b0;
      master = '0;
      vsd_miso = 1'b0;
      sd_miso = 1'b0;
      tape = '0;
      cas_file_bit = 1'b0;
      adc_bit = 1'b0;
      adc_active = 1'b0;
      cas_motor = 1'b0;
      dl_active = 1'b0;
      dl_index = '0;
      loader_rd = '0;
      cas_rd = '0;
      tick(2);
      rst = 1'b0;
      tick(1);
      test_reset();
      test_crop();
      test_vsd();
      test_glow(1'b0);
      test_glow(1'b1);
      test_tape();
      errors += u_dut.u_assert.fail_cnt;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+.
msx_shell_pkg.sv
video_crop.sv
sd_route.sv
media_route.sv
msx_shell_top.sv
msx_shell_assert.sv
tb_msx_shell.sv

// ==== Bender.yml ====
package:
  name: msx_shell

export_include_dirs:
  - .

sources:
  - msx_shell_pkg.sv
  - video_crop.sv
  - sd_route.sv
  - media_route.sv
  - msx_shell_top.sv
  - target: test
    files:
      - msx_shell_assert.sv
      - tb_msx_shell.sv
